//--- hdl/fe_pkg.sv
/*
  Shared widths and types for the instruction-fetch front end.
  Every block refers to these by scoped name.
*/
`default_nettype none

package fe_pkg;

  // fetch and target addresses
  localparam int addr_w = 32;
  typedef logic [addr_w-1:0] addr_t;

  // global branch history
  localparam int hist_w = 8;
  typedef logic [hist_w-1:0] ghr_t;

  localparam int tb_sets_w = 6;  // 64 sets in the target buffer

  // predictor tables, 256 entries of one bit per slot
  localparam int tab_idx_w = 8;
  typedef logic [tab_idx_w-1:0] tab_idx_t;

  // bytes per fetch block, low address bits are the block offset
  localparam int fetch_step = 16;
  localparam int off_w = $clog2(fetch_step);

  typedef logic slot_t;  // target buffer slot 0 or 1

endpackage

`default_nettype wire

//--- hdl/next_ip_gen.sv
/*
  Fetch address and global history registers.
  Picks the next block from the target buffer hits and predicted directions,
  slot 0 first. A mispredict from retire overrides prediction and stall.
*/
`default_nettype none

module next_ip_gen #(
  parameter fe_pkg::addr_t reset_ip = 32'h0000_1000
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          fetch_stall,
  input  logic [1:0]    hit,
  input  logic [1:0]    pred_bits,
  input  fe_pkg::addr_t tgt0,
  input  fe_pkg::addr_t tgt1,
  input  logic          upd_valid,
  input  logic          upd_mispredict,
  input  fe_pkg::addr_t upd_target,
  input  fe_pkg::ghr_t  upd_ghr,
  output fe_pkg::addr_t fetch_ip,
  output fe_pkg::ghr_t  fetch_ghr,
  output logic          fetch_taken
);

  localparam int hw = fe_pkg::hist_w;

  logic          take0;
  logic          take1;
  logic          redirect;
  fe_pkg::addr_t seq_ip;
  fe_pkg::addr_t next_ip;
  fe_pkg::ghr_t  next_ghr;

  assign take0    = hit[0] && pred_bits[0];
  assign take1    = hit[1] && pred_bits[1] && !take0;  // slot 0 wins
  assign redirect = upd_valid && upd_mispredict;

  assign fetch_taken = take0 || take1;
  assign seq_ip      = fetch_ip + fe_pkg::addr_t'(fe_pkg::fetch_step);

  always_comb begin
    if (take0) begin
      next_ip  = tgt0;
      next_ghr = {fetch_ghr[hw-2:0], 1'b1};
    end else if (take1) begin
      // slot 0 not taken, then slot 1 taken
      next_ip  = tgt1;
      next_ghr = {fetch_ghr[hw-3:0], 2'b01};
    end else if (|hit) begin
      next_ip  = seq_ip;
      next_ghr = {fetch_ghr[hw-3:0], 2'b00};
    end else begin
      next_ip  = seq_ip;  // no branch known in this block
      next_ghr = fetch_ghr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip  <= reset_ip;
      fetch_ghr <= '0;
    end else if (redirect) begin
      fetch_ip  <= upd_target;
      fetch_ghr <= upd_ghr;  // restore history from retire
    end else if (!fetch_stall) begin
      fetch_ip  <= next_ip;
      fetch_ghr <= next_ghr;
    end
  end

endmodule

`default_nettype wire

//--- hdl/target_buffer.sv
/*
  Branch target buffer with two tagged slots per set.
  Lookup on fetch_ip is combinational. A retire update writes one slot,
  which the lookup sees from the following cycle.
*/
`default_nettype none

module target_buffer #(
  parameter int tb_sets_w = fe_pkg::tb_sets_w
) (
  input  logic          clk,
  input  logic          rst,
  input  fe_pkg::addr_t fetch_ip,
  input  logic          upd_valid,
  input  fe_pkg::slot_t upd_slot,
  input  fe_pkg::addr_t upd_src_ip,
  input  fe_pkg::addr_t upd_target,
  output logic [1:0]    hit,
  output fe_pkg::addr_t tgt0,
  output fe_pkg::addr_t tgt1
);

  localparam int sets  = 1 << tb_sets_w;
  localparam int tag_w = fe_pkg::addr_w - fe_pkg::off_w - tb_sets_w;

  logic [1:0][sets-1:0] valid_q;
  logic [tag_w-1:0]     tag_mem [2][sets];
  fe_pkg::addr_t        tgt_mem [2][sets];

  logic [tb_sets_w-1:0] rd_set;
  logic [tb_sets_w-1:0] wr_set;
  logic [tag_w-1:0]     rd_tag;
  logic [tag_w-1:0]     wr_tag;

  // set index sits just above the block offset, tag is everything above
  assign rd_set = fetch_ip[fe_pkg::off_w +: tb_sets_w];
  assign rd_tag = fetch_ip[fe_pkg::addr_w-1 -: tag_w];
  assign wr_set = upd_src_ip[fe_pkg::off_w +: tb_sets_w];
  assign wr_tag = upd_src_ip[fe_pkg::addr_w-1 -: tag_w];

  for (genvar s = 0; s < 2; s++) begin : g_slot
    assign hit[s] = valid_q[s][rd_set] && (tag_mem[s][rd_set] == rd_tag);
  end

  assign tgt0 = tgt_mem[0][rd_set];
  assign tgt1 = tgt_mem[1][rd_set];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (upd_valid) begin
      valid_q[upd_slot][wr_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid) begin
      tag_mem[upd_slot][wr_set] <= wr_tag;
      tgt_mem[upd_slot][wr_set] <= upd_target;
    end
  end

endmodule

`default_nettype wire

//--- hdl/direction_predictor.sv
/*
  Direction predictor built from three tables of two-bit entries.
  Each table blends fetch address and global history differently. The three
  entries are xor-combined into one bit per target buffer slot. A mispredict
  update flips the retiring slot's bit in all three tables.
*/
`default_nettype none

module direction_predictor (
  input  logic          clk,
  input  logic          rst,
  input  fe_pkg::addr_t fetch_ip,
  input  fe_pkg::ghr_t  fetch_ghr,
  input  logic          upd_valid,
  input  logic          upd_mispredict,
  input  fe_pkg::slot_t upd_slot,
  input  fe_pkg::addr_t upd_src_ip,
  input  fe_pkg::ghr_t  upd_ghr,
  output logic [1:0]    pred_bits
);

  localparam int entries = 1 << fe_pkg::tab_idx_w;

  logic [2:0][1:0] rd_bits;  // one entry per table
  logic            flip_en;

  assign flip_en = upd_valid && upd_mispredict;

  // table 0 uses ip[9:4] with 2 history bits, table 1 ip[7:4] with 4,
  // table 2 ip[5:4] with 6
  for (genvar t = 0; t < 3; t++) begin : g_tab
    localparam int hb = 2 * (t + 1);
    localparam int ab = fe_pkg::tab_idx_w - hb;

    logic [entries-1:0][1:0] tab_q;
    fe_pkg::tab_idx_t        rd_idx;
    fe_pkg::tab_idx_t        wr_idx;

    assign rd_idx = {fetch_ip[fe_pkg::off_w +: ab], fetch_ghr[hb-1:0]};
    assign wr_idx = {upd_src_ip[fe_pkg::off_w +: ab], upd_ghr[hb-1:0]};

    assign rd_bits[t] = tab_q[rd_idx];

    always_ff @(posedge clk) begin
      if (rst) begin
        tab_q <= '0;
      end else if (flip_en) begin
        tab_q[wr_idx][upd_slot] <= ~tab_q[wr_idx][upd_slot];  // toggle direction
      end
    end
  end

  assign pred_bits = rd_bits[0] ^ rd_bits[1] ^ rd_bits[2];

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
/*
  Instruction-fetch front end top level.
  Connects the fetch address generator, the branch target buffer and the
  direction predictor. Retire updates come in as a one-cycle pulse.
*/
`default_nettype none

module fetch_frontend #(
  parameter fe_pkg::addr_t reset_ip  = 32'h0000_1000,
  parameter int            tb_sets_w = fe_pkg::tb_sets_w
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          fetch_stall,
  input  logic          upd_valid,
  input  fe_pkg::slot_t upd_slot,
  input  fe_pkg::addr_t upd_src_ip,
  input  fe_pkg::addr_t upd_target,
  input  fe_pkg::ghr_t  upd_ghr,
  input  logic          upd_mispredict,
  output fe_pkg::addr_t fetch_ip,
  output fe_pkg::ghr_t  fetch_ghr,
  output logic          fetch_taken
);

  logic [1:0]    hit;        // per slot, current block
  logic [1:0]    pred_bits;  // per slot direction
  fe_pkg::addr_t tgt0;
  fe_pkg::addr_t tgt1;

  next_ip_gen #(
    .reset_ip (reset_ip)
  ) next_ip_gen_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_stall    (fetch_stall),
    .hit            (hit),
    .pred_bits      (pred_bits),
    .tgt0           (tgt0),
    .tgt1           (tgt1),
    .upd_valid      (upd_valid),
    .upd_mispredict (upd_mispredict),
    .upd_target     (upd_target),
    .upd_ghr        (upd_ghr),
    .fetch_ip       (fetch_ip),
    .fetch_ghr      (fetch_ghr),
    .fetch_taken    (fetch_taken)
  );

  target_buffer #(
    .tb_sets_w (tb_sets_w)
  ) target_buffer_i (
    .clk        (clk),
    .rst        (rst),
    .fetch_ip   (fetch_ip),
    .upd_valid  (upd_valid),
    .upd_slot   (upd_slot),
    .upd_src_ip (upd_src_ip),
    .upd_target (upd_target),
    .hit        (hit),
    .tgt0       (tgt0),
    .tgt1       (tgt1)
  );

  direction_predictor direction_predictor_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_ip       (fetch_ip),
    .fetch_ghr      (fetch_ghr),
    .upd_valid      (upd_valid),
    .upd_mispredict (upd_mispredict),
    .upd_slot       (upd_slot),
    .upd_src_ip     (upd_src_ip),
    .upd_ghr        (upd_ghr),
    .pred_bits      (pred_bits)
  );

endmodule

`default_nettype wire

//--- dv/fetch_frontend_props.sv
/*
  Concurrent checks on the fetch front end, bound into the top level.
  Covers reset loading, stall hold and sequential block stepping.
*/
`default_nettype none

module fetch_frontend_props #(
  parameter fe_pkg::addr_t reset_ip = 32'h0000_1000
) (
  input logic          clk,
  input logic          rst,
  input logic          fetch_stall,
  input logic          upd_valid,
  input logic          upd_mispredict,
  input fe_pkg::addr_t fetch_ip,
  input fe_pkg::ghr_t  fetch_ghr,
  input logic          fetch_taken
);

  logic redirect;

  assign redirect = upd_valid && upd_mispredict;

  reset_loads_ip: assert property (@(posedge clk) rst |=> fetch_ip == reset_ip)
    else $error("fetch_ip did not load the reset address");

  stall_holds: assert property (@(posedge clk) disable iff (rst)
    fetch_stall && !redirect |=> $stable(fetch_ip) && $stable(fetch_ghr))
    else $error("fetch state moved during a stall");

  // sequential block when nothing is taken
  seq_step: assert property (@(posedge clk) disable iff (rst)
    !fetch_stall && !fetch_taken && !redirect
      |=> fetch_ip == $past(fetch_ip) + fe_pkg::addr_t'(fe_pkg::fetch_step))
    else $error("fetch_ip did not step by one fetch block");

endmodule

bind fetch_frontend fetch_frontend_props #(
  .reset_ip (reset_ip)
) fetch_frontend_props_i (
  .clk            (clk),
  .rst            (rst),
  .fetch_stall    (fetch_stall),
  .upd_valid      (upd_valid),
  .upd_mispredict (upd_mispredict),
  .fetch_ip       (fetch_ip),
  .fetch_ghr      (fetch_ghr),
  .fetch_taken    (fetch_taken)
);

`default_nettype wire

//--- dv/fetch_frontend_tb.sv
/*
  Testbench for the fetch front end.
  Applies a table of stall and retire update values, one row per clock,
  and checks fetch_ip, fetch_ghr and fetch_taken after each edge.
*/
`default_nettype none

module fetch_frontend_tb;

  localparam int n_rows       = 30;
  localparam int reset_cycles = 16;
  localparam int cycle_limit  = 2 * n_rows + reset_cycles;

  typedef struct packed {
    logic          stall;
    logic          upd_valid;
    fe_pkg::slot_t upd_slot;
    fe_pkg::addr_t upd_src_ip;
    fe_pkg::addr_t upd_target;
    fe_pkg::ghr_t  upd_ghr;
    logic          upd_mispredict;
    fe_pkg::addr_t exp_ip;
    fe_pkg::ghr_t  exp_ghr;
    logic          exp_taken;
  } row_t;

  logic          clk;
  logic          rst;
  logic          fetch_stall;
  logic          upd_valid;
  fe_pkg::slot_t upd_slot;
  fe_pkg::addr_t upd_src_ip;
  fe_pkg::addr_t upd_target;
  fe_pkg::ghr_t  upd_ghr;
  logic          upd_mispredict;
  fe_pkg::addr_t fetch_ip;
  fe_pkg::ghr_t  fetch_ghr;
  logic          fetch_taken;

  row_t rows [n_rows];
  int   err_ip;
  int   err_ghr;
  int   err_taken;
  int   cycles;

  fetch_frontend fetch_frontend_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_stall    (fetch_stall),
    .upd_valid      (upd_valid),
    .upd_slot       (upd_slot),
    .upd_src_ip     (upd_src_ip),
    .upd_target     (upd_target),
    .upd_ghr        (upd_ghr),
    .upd_mispredict (upd_mispredict),
    .fetch_ip       (fetch_ip),
    .fetch_ghr      (fetch_ghr),
    .fetch_taken    (fetch_taken)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stall, valid, slot, src, target, upd ghr, mispredict, then expected ip, ghr, taken
  task automatic fill_table();
    rows[0]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1010, 8'h00, 1'b0};
    rows[1]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1020, 8'h00, 1'b0};
    rows[2]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1030, 8'h00, 1'b0};
    // install slot 0 at 0x1060 while stalled
    rows[3]  = '{1'b1, 1'b1, 1'b0, 32'h1060, 32'h2000, 8'h00, 1'b0, 32'h1030, 8'h00, 1'b0};
    // second stalled install at 0x10d0, first reached with nonzero history
    rows[4]  = '{1'b1, 1'b1, 1'b0, 32'h10d0, 32'h2000, 8'h00, 1'b0, 32'h1030, 8'h00, 1'b0};
    rows[5]  = '{1'b1, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1030, 8'h00, 1'b0};
    rows[6]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1040, 8'h00, 1'b0};
    rows[7]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1050, 8'h00, 1'b0};
    rows[8]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1060, 8'h00, 1'b0};
    rows[9]  = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1070, 8'h00, 1'b0};
    // mispredict slot 0 with a target back at 0x1040
    rows[10] = '{1'b0, 1'b1, 1'b0, 32'h1060, 32'h1040, 8'h05, 1'b1, 32'h1040, 8'h05, 1'b0};
    rows[11] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1050, 8'h05, 1'b0};
    rows[12] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1060, 8'h05, 1'b1};
    rows[13] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1040, 8'h0b, 1'b0};
    rows[14] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1050, 8'h0b, 1'b0};
    rows[15] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1060, 8'h0b, 1'b0};
    rows[16] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1070, 8'h2c, 1'b0};
    // both slots of set 9 with the same history
    rows[17] = '{1'b0, 1'b1, 1'b1, 32'h1090, 32'h3010, 8'h12, 1'b1, 32'h3010, 8'h12, 1'b0};
    rows[18] = '{1'b0, 1'b1, 1'b0, 32'h1090, 32'h1080, 8'h12, 1'b1, 32'h1080, 8'h12, 1'b0};
    rows[19] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1090, 8'h12, 1'b1};
    rows[20] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1080, 8'h25, 1'b0};
    rows[21] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h1090, 8'h25, 1'b0};
    rows[22] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10a0, 8'h94, 1'b0};
    // slot 1 alone at set 12
    rows[23] = '{1'b0, 1'b1, 1'b1, 32'h10c0, 32'h10b0, 8'h33, 1'b1, 32'h10b0, 8'h33, 1'b0};
    rows[24] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10c0, 8'h33, 1'b1};
    rows[25] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10b0, 8'hcd, 1'b0};
    rows[26] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10c0, 8'hcd, 1'b0};
    rows[27] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10d0, 8'h34, 1'b0};
    rows[28] = '{1'b1, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10d0, 8'h34, 1'b0};
    rows[29] = '{1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0, 32'h10e0, 8'hd0, 1'b0};
  endtask

  task automatic drive_row(input row_t r);
    fetch_stall    = r.stall;
    upd_valid      = r.upd_valid;
    upd_slot       = r.upd_slot;
    upd_src_ip     = r.upd_src_ip;
    upd_target     = r.upd_target;
    upd_ghr        = r.upd_ghr;
    upd_mispredict = r.upd_mispredict;
  endtask

  task automatic check_ip(input fe_pkg::addr_t got, input fe_pkg::addr_t exp, input int row);
    if (got !== exp) begin
      $display("error: t=%0t row %0d fetch_ip 0x%08h, expected 0x%08h", $time, row, got, exp);
      err_ip++;
    end
  endtask

  task automatic check_ghr(input fe_pkg::ghr_t got, input fe_pkg::ghr_t exp, input int row);
    if (got !== exp) begin
      $display("error: t=%0t row %0d fetch_ghr 0x%02h, expected 0x%02h", $time, row, got, exp);
      err_ghr++;
    end
  endtask

  task automatic check_taken(input logic got, input logic exp, input int row);
    if (got !== exp) begin
      $display("error: t=%0t row %0d fetch_taken %b, expected %b", $time, row, got, exp);
      err_taken++;
    end
  endtask

  // stimulus and verdict
  initial begin
    rst            = 1'b1;
    fetch_stall    = 1'b0;
    upd_valid      = 1'b0;
    upd_slot       = 1'b0;
    upd_src_ip     = '0;
    upd_target     = '0;
    upd_ghr        = '0;
    upd_mispredict = 1'b0;
    err_ip         = 0;
    err_ghr        = 0;
    err_taken      = 0;
    fill_table();
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      drive_row(rows[i]);
      @(negedge clk);  // outputs settled since the rising edge
      check_ip(fetch_ip, rows[i].exp_ip, i);
      check_ghr(fetch_ghr, rows[i].exp_ghr, i);
      check_taken(fetch_taken, rows[i].exp_taken, i);
    end
    $display("errors: fetch_ip %0d, fetch_ghr %0d, fetch_taken %0d", err_ip, err_ghr, err_taken);
    if (err_ip + err_ghr + err_taken == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("simulation timed out after %0d cycles without finishing the table", cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_frontend.f
hdl/fe_pkg.sv
hdl/next_ip_gen.sv
hdl/target_buffer.sv
hdl/direction_predictor.sv
hdl/fetch_frontend.sv
dv/fetch_frontend_props.sv
dv/fetch_frontend_tb.sv

//--- Makefile
# Verilator flow for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= fetch_frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
